/* tb/testdata_bridge.txt */
# R addr data pend fail bcast : one received bus word, frame ends at pend 0 or fail 1
# T eid addr nwords fail trunc : command frame, followed by nwords lines "D data"
R 00000012 a1b2c3d4 0 0 0
R 00000034 11111111 1 0 0
R 00000034 22222222 1 0 0
R 00000034 33333333 0 0 0
R 00000056 44444444 1 0 1
R 00000056 55555555 0 0 0
R 00000078 66666666 1 0 0
R 00000078 77777777 0 1 0
R 0000009a 88888888 0 1 1
R 000000bc 99999999 0 0 0
T 21 10002000 2 0 0
D cafef00d
D 12345678
T 22 10003000 2 1 0
D deadbeef
D 00c0ffee
T 23 10004000 1 0 3
D 0badf00d
T 24 10005000 1 0 5
D 01020304
T 25 10006000 1 0 7
D a5a5a5a5
T 26 10007000 3 0 0
D 13579bdf
D 2468ace0
D 0f1e2d3c
T 27 10008000 1 1 0
D 55aa55aa

/* sim.f */
source/host_frame_pkg.sv
source/bus_word_pkg.sv
source/rx_framer.sv
source/tx_deframer.sv
source/reply_merger.sv
source/mbus_bridge_top.sv
tb/tb_mbus_bridge.sv

/* tb/tb_mbus_bridge.sv */
// Bridge testbench with bus-layer model, host model, expected queues and checks
`timescale 1ns/1ps
`default_nettype none

module tb_mbus_bridge
	import host_frame_pkg::*;
	import bus_word_pkg::*;
();

	localparam host_byte_t FLAG = 8'h7e;
	localparam host_byte_t TAG_BASE = 8'h10;
	localparam int TIMEOUT = 2000;

	logic clk = 1'b0;
	logic reset;
	host_byte_t time_tag;
	logic tag_incr;
	bus_word_t rx_addr, rx_data;
	logic rx_req, rx_pend, rx_fail, rx_bcast, rx_ack;
	bus_word_t tx_addr, tx_data;
	logic tx_pend, tx_req, tx_ack, tx_succ, tx_fail;
	host_byte_t in_data;
	logic in_valid, in_last, in_ready;
	host_byte_t out_data;
	logic out_valid, out_last, out_ready;

	// Case tables loaded from the data file
	bus_word_t rw_addr[$], rw_data[$];
	logic rw_pend[$], rw_fail[$], rw_bcast[$];
	host_byte_t tc_eid[$];
	bus_word_t tc_addr[$], tw_data[$];
	int tc_nw[$], tc_fail[$], tc_trunc[$], tc_first[$];

	// Expected host bytes with the last flag in bit 8
	logic [8:0] rx_exp[$], reply_exp[$];

	int errors = 0;
	int passed = 0;
	int failed = 0;
	int tag_count = 0;
	int rx_frames = 0;
	int rx_done = 0;
	int reply_done = 0;
	int frame_err_start;
	logic in_frame = 1'b0;
	logic frame_is_rx;
	int frame_pos;
	logic bus_expect = 1'b0;
	logic [15:0] lfsr = 16'd5;

	mbus_bridge_top #(
		.FLAG_BYTE(FLAG)
	) uut (
		.clk(clk), .reset(reset), .time_tag(time_tag), .tag_incr(tag_incr),
		.rx_addr(rx_addr), .rx_data(rx_data), .rx_req(rx_req), .rx_pend(rx_pend),
		.rx_fail(rx_fail), .rx_bcast(rx_bcast), .rx_ack(rx_ack),
		.tx_addr(tx_addr), .tx_data(tx_data), .tx_pend(tx_pend), .tx_req(tx_req),
		.tx_ack(tx_ack), .tx_succ(tx_succ), .tx_fail(tx_fail),
		.in_data(in_data), .in_valid(in_valid), .in_last(in_last), .in_ready(in_ready),
		.out_data(out_data), .out_valid(out_valid), .out_last(out_last),
		.out_ready(out_ready)
	);

	always #4 clk = ~clk;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic compare_byte(input string name, input host_byte_t got, input host_byte_t exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_word(input string name, input bus_word_t got, input bus_word_t exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_kind(input string name, input reply_kind_e got,
			input reply_kind_e exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	// Random back-pressure from two LFSR bits per cycle
	always @(posedge clk) begin
		logic b0;
		#1;
		lfsr = lfsr_next(lfsr);
		b0 = lfsr[0];
		lfsr = lfsr_next(lfsr);
		out_ready = b0 | lfsr[0];
	end

	always @(posedge clk) begin
		if (!reset && tag_incr) begin
			tag_count++;
			time_tag <= #1 time_tag + 8'd1;
		end
		if (!reset && tx_req && !bus_expect) begin
			$display("tx_req raised at t=%0t while no bus word was expected", $time);
			errors++;
		end
	end

	// Host output monitor that sorts frames by their first byte
	always @(posedge clk) begin
		logic [8:0] exp;
		if (!reset && out_valid && out_ready) begin
			if (!in_frame) begin
				in_frame = 1'b1;
				frame_is_rx = (out_data == FLAG);
				frame_pos = 0;
				frame_err_start = errors;
			end
			if (frame_is_rx ? rx_exp.size() == 0 : reply_exp.size() == 0) begin
				$display("Unexpected output byte %h at t=%0t", out_data, $time);
				errors++;
				exp = {out_last, out_data};
			end else begin
				exp = frame_is_rx ? rx_exp.pop_front() : reply_exp.pop_front();
			end
			if (!frame_is_rx && frame_pos == 0)
				compare_kind("out_data", reply_kind_e'(out_data), reply_kind_e'(exp[7:0]));
			else
				compare_byte("out_data", out_data, exp[7:0]);
			compare_bit("out_last", out_last, exp[8]);
			frame_pos++;
			if (out_last) begin
				in_frame = 1'b0;
				if (errors == frame_err_start)
					passed++;
				else
					failed++;
				$display("%s case %0d: %s", frame_is_rx ? "rx" : "tx",
					frame_is_rx ? rx_done : reply_done,
					errors == frame_err_start ? "ok" : "mismatch");
				if (frame_is_rx)
					rx_done++;
				else
					reply_done++;
			end
		end
	end

	task automatic load_cases();
		int fd;
		string line, tok;
		logic [31:0] a, d;
		int p, f, b, n;
		fd = $fopen("tb/testdata_bridge.txt", "r");
		if (fd == 0) begin
			$display("Cannot open tb/testdata_bridge.txt");
			$display("Simulation finished: FAIL");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) == 0)
					continue;
				if ($sscanf(line, "%s", tok) != 1)
					continue;
				if (tok == "R") begin
					void'($sscanf(line, "%s %h %h %d %d %d", tok, a, d, p, f, b));
					rw_addr.push_back(a);
					rw_data.push_back(d);
					rw_pend.push_back(p[0]);
					rw_fail.push_back(f[0]);
					rw_bcast.push_back(b[0]);
				end else if (tok == "T") begin
					void'($sscanf(line, "%s %h %h %d %d %d", tok, d, a, n, f, b));
					tc_eid.push_back(d[7:0]);
					tc_addr.push_back(a);
					tc_nw.push_back(n);
					tc_fail.push_back(f);
					tc_trunc.push_back(b);
					tc_first.push_back(tw_data.size());
				end else if (tok == "D") begin
					void'($sscanf(line, "%s %h", tok, d));
					tw_data.push_back(d);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic push_word(input bus_word_t w);
		for (int i = 3; i >= 0; i--)
			rx_exp.push_back({1'b0, w[8 * i +: 8]});
	endtask

	task automatic send_rx_word(input int k);
		int cnt;
		cnt = 0;
		rx_addr = rw_addr[k];
		rx_data = rw_data[k];
		rx_pend = rw_pend[k];
		rx_fail = rw_fail[k];
		rx_bcast = rw_bcast[k];
		rx_req = 1'b1;
		do begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT)
				abort_on_timeout("rx_ack");
		end while (!rx_ack);
		#1 rx_req = 1'b0;
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic run_rx_cases();
		int i, j;
		host_byte_t status;
		i = 0;
		while (i < rw_addr.size()) begin
			j = i;
			while (rw_pend[j] && !rw_fail[j] && j < rw_addr.size() - 1)
				j++;
			// Expected frame holds flag, tag, first address, good data words and status
			status = '0;
			rx_exp.push_back({1'b0, FLAG});
			rx_exp.push_back({1'b0, TAG_BASE + host_byte_t'(rx_frames)});
			push_word(rw_addr[i]);
			for (int k = i; k <= j; k++) begin
				status[STATUS_FAIL_BIT] |= rw_fail[k];
				status[STATUS_BCAST_BIT] |= rw_bcast[k];
				if (!rw_fail[k])
					push_word(rw_data[k]);
			end
			rx_exp.push_back({1'b1, status});
			rx_frames++;
			for (int k = i; k <= j; k++)
				send_rx_word(k);
			i = j + 1;
		end
	endtask

	task automatic send_byte(input host_byte_t b, input logic last);
		int cnt;
		cnt = 0;
		in_data = b;
		in_valid = 1'b1;
		in_last = last;
		do begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT)
				abort_on_timeout("in_ready");
		end while (!in_ready);
		#1;
		in_valid = 1'b0;
		in_last = 1'b0;
	endtask

	task automatic serve_bus_word(input int c, input int w);
		int cnt;
		cnt = 0;
		bus_expect = 1'b1;
		do begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT)
				abort_on_timeout("tx_req");
		end while (!tx_req);
		compare_word("tx_addr", tx_addr, tc_addr[c]);
		compare_word("tx_data", tx_data, tw_data[tc_first[c] + w]);
		compare_bit("tx_pend", tx_pend, w != tc_nw[c] - 1);
		#1 tx_ack = 1'b1;
		@(posedge clk);
		#1;
		tx_ack = 1'b0;
		bus_expect = 1'b0;
		if (w == tc_nw[c] - 1) begin
			tx_succ = (tc_fail[c] == 0);
			tx_fail = (tc_fail[c] != 0);
			@(posedge clk);
			#1;
			tx_succ = 1'b0;
			tx_fail = 1'b0;
		end
	endtask

	task automatic run_tx_cases();
		host_byte_t bytes[$];
		int n;
		reply_kind_e kind;
		for (int c = 0; c < tc_eid.size(); c++) begin
			bytes.delete();
			bytes.push_back(tc_eid[c]);
			for (int i = 3; i >= 0; i--)
				bytes.push_back(tc_addr[c][8 * i +: 8]);
			for (int w = 0; w < tc_nw[c]; w++)
				for (int i = 3; i >= 0; i--)
					bytes.push_back(tw_data[tc_first[c] + w][8 * i +: 8]);
			n = (tc_trunc[c] > 0) ? tc_trunc[c] : bytes.size();
			kind = (tc_trunc[c] > 0 || tc_fail[c] != 0) ? REPLY_NAK : REPLY_ACK;
			reply_exp.push_back({1'b0, 8'(kind)});
			reply_exp.push_back({1'b1, tc_eid[c]});
			for (int b = 0; b < n; b++) begin
				send_byte(bytes[b], b == n - 1);
				if (tc_trunc[c] == 0 && b >= 5 && (b - 5) % 4 == 3)
					serve_bus_word(c, (b - 5) / 4);
			end
		end
	endtask

	initial begin
		int cnt;
		reset = 1'b1;
		time_tag = TAG_BASE;
		rx_addr = '0;
		rx_data = '0;
		rx_req = 1'b0;
		rx_pend = 1'b0;
		rx_fail = 1'b0;
		rx_bcast = 1'b0;
		tx_ack = 1'b0;
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		in_data = '0;
		in_valid = 1'b0;
		in_last = 1'b0;
		out_ready = 1'b0;
		load_cases();
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		// Receive and transmit cases overlap on purpose
		fork
			run_rx_cases();
			run_tx_cases();
		join
		cnt = 0;
		while (rx_exp.size() != 0 || reply_exp.size() != 0 || in_frame) begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT)
				abort_on_timeout("the remaining output frames");
		end
		if (tag_count != rx_frames) begin
			$display("FAILED t=%0t tag_incr count: got %0d expected %0d",
				$time, tag_count, rx_frames);
			errors++;
		end
		$display("Cases: %0d passed, %0d failed, %0d check errors", passed, failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* source/mbus_bridge_top.sv */
// Bridge top level: receive framer, transmit deframer and output merger
`timescale 1ns/1ps
`default_nettype none

module mbus_bridge_top
	import host_frame_pkg::*;
	import bus_word_pkg::*;
#(
	parameter host_byte_t FLAG_BYTE = DEFAULT_FLAG
) (
	input wire clk,
	input wire reset,
	input wire host_byte_t time_tag,
	output logic tag_incr,
	input wire bus_word_t rx_addr,
	input wire bus_word_t rx_data,
	input wire rx_req,
	input wire rx_pend,
	input wire rx_fail,
	input wire rx_bcast,
	output logic rx_ack,
	output bus_word_t tx_addr,
	output bus_word_t tx_data,
	output logic tx_pend,
	output logic tx_req,
	input wire tx_ack,
	input wire tx_succ,
	input wire tx_fail,
	input wire host_byte_t in_data,
	input wire in_valid,
	input wire in_last,
	output logic in_ready,
	output host_byte_t out_data,
	output logic out_valid,
	output logic out_last,
	input wire out_ready
);

	// Received frame stream
	host_byte_t rf_data;
	logic rf_valid, rf_last, rf_ready;

	// Command outcome
	logic res_valid, res_ready;
	reply_kind_e res_kind;
	host_byte_t res_eid;

	rx_framer #(
		.FLAG_BYTE(FLAG_BYTE)
	) u_rx_framer (
		.clk(clk), .reset(reset),
		.time_tag(time_tag), .tag_incr(tag_incr),
		.rx_addr(rx_addr), .rx_data(rx_data), .rx_req(rx_req),
		.rx_pend(rx_pend), .rx_fail(rx_fail), .rx_bcast(rx_bcast), .rx_ack(rx_ack),
		.rf_data(rf_data), .rf_valid(rf_valid), .rf_last(rf_last), .rf_ready(rf_ready)
	);

	tx_deframer u_tx_deframer (
		.clk(clk), .reset(reset),
		.in_data(in_data), .in_valid(in_valid), .in_last(in_last), .in_ready(in_ready),
		.tx_addr(tx_addr), .tx_data(tx_data), .tx_pend(tx_pend), .tx_req(tx_req),
		.tx_ack(tx_ack), .tx_succ(tx_succ), .tx_fail(tx_fail),
		.res_valid(res_valid), .res_ready(res_ready),
		.res_kind(res_kind), .res_eid(res_eid)
	);

	reply_merger u_reply_merger (
		.clk(clk), .reset(reset),
		.rf_data(rf_data), .rf_valid(rf_valid), .rf_last(rf_last), .rf_ready(rf_ready),
		.res_valid(res_valid), .res_ready(res_ready),
		.res_kind(res_kind), .res_eid(res_eid),
		.out_data(out_data), .out_valid(out_valid), .out_last(out_last),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

/* source/reply_merger.sv */
// Output merger: received frames and two-byte replies onto the host output
`timescale 1ns/1ps
`default_nettype none

module reply_merger
	import host_frame_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire host_byte_t rf_data,
	input wire rf_valid,
	input wire rf_last,
	output logic rf_ready,
	input wire res_valid,
	output logic res_ready,
	input wire reply_kind_e res_kind,
	input wire host_byte_t res_eid,
	output host_byte_t out_data,
	output logic out_valid,
	output logic out_last,
	input wire out_ready
);

	merge_src_e owner;
	merge_src_e sel;
	logic byte_idx;

	// Pick a new source only between frames, replies first
	always_comb begin
		if (owner != SRC_NONE)
			sel = owner;
		else if (res_valid)
			sel = SRC_REPLY;
		else if (rf_valid)
			sel = SRC_RX;
		else
			sel = SRC_NONE;
	end

	always_comb begin
		out_data = '0;
		out_valid = 1'b0;
		out_last = 1'b0;
		rf_ready = 1'b0;
		res_ready = 1'b0;
		case (sel)
			SRC_RX: begin
				out_data = rf_data;
				out_valid = rf_valid;
				out_last = rf_last;
				rf_ready = out_ready;
			end
			SRC_REPLY: begin
				// Kind byte then eid byte
				out_data = byte_idx ? res_eid : host_byte_t'(res_kind);
				out_valid = res_valid;
				out_last = byte_idx;
				res_ready = out_ready & byte_idx;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			owner <= SRC_NONE;
			byte_idx <= 1'b0;
		end else begin
			if (out_valid && out_ready && out_last)
				owner <= SRC_NONE;
			else
				owner <= sel;
			if (sel == SRC_REPLY && out_valid && out_ready)
				byte_idx <= ~byte_idx;
		end
	end

endmodule

`default_nettype wire

/* source/tx_deframer.sv */
// Transmit deframer: host command frames into bus word requests plus outcome
`timescale 1ns/1ps
`default_nettype none

module tx_deframer
	import host_frame_pkg::*;
	import bus_word_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire host_byte_t in_data,
	input wire in_valid,
	input wire in_last,
	output logic in_ready,
	output bus_word_t tx_addr,
	output bus_word_t tx_data,
	output logic tx_pend,
	output logic tx_req,
	input wire tx_ack,
	input wire tx_succ,
	input wire tx_fail,
	output logic res_valid,
	input wire res_ready,
	output reply_kind_e res_kind,
	output host_byte_t res_eid
);

	typedef enum logic [2:0] {
		EID, ADDR, DATA, REQUEST, WAIT_DONE, REPORT
	} tx_state_e;

	tx_state_e state;
	logic [1:0] byte_cnt;
	logic in_take;
	logic word_done;

	assign in_ready = (state == EID) || (state == ADDR) || (state == DATA);
	assign in_take = in_valid & in_ready;
	assign word_done = (byte_cnt == 2'(BYTES_PER_WORD - 1));
	assign tx_req = (state == REQUEST);
	assign res_valid = (state == REPORT);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= EID;
			byte_cnt <= 2'd0;
			tx_pend <= 1'b0;
		end else begin
			case (state)
				EID: begin
					if (in_take) begin
						byte_cnt <= 2'd0;
						state <= in_last ? REPORT : ADDR;
					end
				end
				ADDR: begin
					if (in_take) begin
						byte_cnt <= byte_cnt + 2'd1;
						// Address alone is a short frame
						if (in_last)
							state <= REPORT;
						else if (word_done)
							state <= DATA;
					end
				end
				DATA: begin
					if (in_take) begin
						byte_cnt <= byte_cnt + 2'd1;
						if (word_done) begin
							state <= REQUEST;
							tx_pend <= ~in_last;
						end else if (in_last) begin
							state <= REPORT;
						end
					end
				end
				REQUEST: begin
					if (tx_ack)
						state <= tx_pend ? DATA : WAIT_DONE;
				end
				WAIT_DONE: begin
					if (tx_succ || tx_fail)
						state <= REPORT;
				end
				REPORT: begin
					if (res_ready)
						state <= EID;
				end
				default: state <= EID;
			endcase
		end
	end

	// Address, data, eid and outcome registers
	always_ff @(posedge clk) begin
		if (in_take) begin
			case (state)
				EID: res_eid <= in_data;
				ADDR: tx_addr <= {tx_addr[23:0], in_data};
				default: tx_data <= {tx_data[23:0], in_data};
			endcase
		end
		if (in_take && in_last && !(state == DATA && word_done))
			res_kind <= REPLY_NAK;
		else if (state == WAIT_DONE && tx_succ)
			res_kind <= REPLY_ACK;
		else if (state == WAIT_DONE && tx_fail)
			res_kind <= REPLY_NAK;
	end

endmodule

`default_nettype wire

/* source/rx_framer.sv */
// Receive framer: bus words from the bus layer into flagged host frames
`timescale 1ns/1ps
`default_nettype none

module rx_framer
	import host_frame_pkg::*;
	import bus_word_pkg::*;
#(
	parameter host_byte_t FLAG_BYTE = DEFAULT_FLAG
) (
	input wire clk,
	input wire reset,
	input wire host_byte_t time_tag,
	output logic tag_incr,
	input wire bus_word_t rx_addr,
	input wire bus_word_t rx_data,
	input wire rx_req,
	input wire rx_pend,
	input wire rx_fail,
	input wire rx_bcast,
	output logic rx_ack,
	output host_byte_t rf_data,
	output logic rf_valid,
	output logic rf_last,
	input wire rf_ready
);

	typedef enum logic [2:0] {
		IDLE, FLAG, TAG, CAPTURE, SHIFT, WAIT_NEXT, STATUS
	} rx_state_e;

	rx_state_e state, state_next;
	logic [1:0] req_sync;
	logic req_taken;
	logic req_new;
	logic first_word;
	logic pend_q, fail_q;
	logic [63:0] shift_q;
	logic [3:0] byte_cnt;
	host_byte_t tag_q;
	host_byte_t status_q;
	host_byte_t word_status;

	// A request counts once; wait for it to drop before taking the next
	assign req_new = req_sync[1] & ~req_taken;

	always_comb begin
		word_status = '0;
		word_status[STATUS_FAIL_BIT] = rx_fail;
		word_status[STATUS_BCAST_BIT] = rx_bcast;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			req_sync <= 2'b00;
			req_taken <= 1'b0;
			rx_ack <= 1'b0;
			first_word <= 1'b1;
		end else begin
			state <= state_next;
			req_sync <= {req_sync[0], rx_req};
			rx_ack <= (state == CAPTURE);
			if (state == CAPTURE)
				req_taken <= 1'b1;
			else if (!req_sync[1])
				req_taken <= 1'b0;
			if (state == IDLE)
				first_word <= 1'b1;
			else if (state == CAPTURE)
				first_word <= 1'b0;
		end
	end

	// Word capture and byte shifter
	always_ff @(posedge clk) begin
		if (state == CAPTURE) begin
			pend_q <= rx_pend;
			fail_q <= rx_fail;
			if (first_word) begin
				tag_q <= time_tag;
				shift_q <= {rx_addr, rx_data};
				byte_cnt <= rx_fail ? 4'(BYTES_PER_WORD) : 4'(2 * BYTES_PER_WORD);
				status_q <= word_status;
			end else begin
				shift_q <= {rx_data, 32'd0};
				byte_cnt <= rx_fail ? 4'd0 : 4'(BYTES_PER_WORD);
				status_q <= status_q | word_status;
			end
		end else if (state == SHIFT && rf_valid && rf_ready) begin
			shift_q <= {shift_q[55:0], 8'h00};
			byte_cnt <= byte_cnt - 4'd1;
		end
	end

	always_comb begin
		state_next = state;
		rf_valid = 1'b0;
		rf_last = 1'b0;
		rf_data = shift_q[63:56];
		tag_incr = 1'b0;
		case (state)
			IDLE, WAIT_NEXT: begin
				if (req_new)
					state_next = CAPTURE;
			end
			CAPTURE: begin
				// Later failed words skip straight to the status byte
				if (first_word)
					state_next = FLAG;
				else if (rx_fail)
					state_next = STATUS;
				else
					state_next = SHIFT;
			end
			FLAG: begin
				rf_valid = 1'b1;
				rf_data = FLAG_BYTE;
				if (rf_ready)
					state_next = TAG;
			end
			TAG: begin
				rf_valid = 1'b1;
				rf_data = tag_q;
				if (rf_ready) begin
					tag_incr = 1'b1;
					state_next = SHIFT;
				end
			end
			SHIFT: begin
				rf_valid = 1'b1;
				if (rf_ready && byte_cnt == 4'd1)
					state_next = (fail_q || !pend_q) ? STATUS : WAIT_NEXT;
			end
			STATUS: begin
				rf_valid = 1'b1;
				rf_last = 1'b1;
				rf_data = status_q;
				if (rf_ready)
					state_next = IDLE;
			end
			default: state_next = IDLE;
		endcase
	end

endmodule

`default_nettype wire

/* source/bus_word_pkg.sv */
// Bus layer word type, status byte bit positions and word size
`default_nettype none

package bus_word_pkg;

	// Address or data word of the bus layer
	typedef logic [31:0] bus_word_t;

	// Status byte layout, remaining bits stay zero
	localparam int STATUS_FAIL_BIT = 3;
	localparam int STATUS_BCAST_BIT = 2;

	localparam int BYTES_PER_WORD = 4;

endpackage

`default_nettype wire

/* source/host_frame_pkg.sv */
// Host stream byte type, reply kinds, merge source codes and default flag byte
`default_nettype none

package host_frame_pkg;

	// One byte of the host byte stream
	typedef logic [7:0] host_byte_t;

	// First byte of a reply frame, also the command outcome
	typedef enum logic [7:0] {
		REPLY_ACK = 8'h06,
		REPLY_NAK = 8'h15
	} reply_kind_e;

	// Current owner of the host output
	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_RX,
		SRC_REPLY
	} merge_src_e;

	// Start byte of every received frame unless overridden
	localparam host_byte_t DEFAULT_FLAG = 8'h42;

endpackage

`default_nettype wire
